/* src.f */
verilog/lsu_pkg.sv
verilog/dcache_way_if.sv
verilog/lsu_align.sv
verilog/dcache_ctrl.sv
verilog/dcache_way.sv
verilog/dcache_hit_sel.sv
verilog/lsu.sv
testbench/lsu_sva.sv
testbench/lsu_tb.sv

/* testbench/lsu_patterns.txt */
# op: 0 load hit, 1 load miss, 2 uncached load, 3 store
# op funct3 address store_data expected_load_data (hex)
1 3 00002040 0 ffffdfbffedc9ad8
0 0 00002040 0 ffffffffffffffd8
0 4 00002041 0 000000000000009a
0 1 00002042 0 fffffffffffffedc
0 5 00002046 0 000000000000ffff
0 2 00002044 0 ffffffffffffdfbf
0 6 00002040 0 00000000fedc9ad8
0 0 0000207b 0 fffffffffffffffe
0 1 0000207c 0 ffffffffffffdf87
1 2 80001100 0 000000007edcab98
0 1 80001106 0 0000000000007fff
0 3 80001100 0 7fffeeff7edcab98
3 0 00002043 0000000000000055 0
0 2 00002040 0 0000000055dc9ad8
3 1 00002046 0000000000001234 0
0 3 00002040 0 1234dfbf55dc9ad8
3 2 00003004 00000000cafef00d 0
1 3 00003000 0 cafef00dfedc8a98
3 3 80001108 0123456789abcdef 0
0 3 80001108 0 0123456789abcdef
1 6 00000080 0 00000000fedcba18
1 6 00000480 0 00000000fedcbe18
1 6 00000880 0 00000000fedcb218
1 6 00000c80 0 00000000fedcb618
1 6 00001080 0 00000000fedcaa18
1 6 00000080 0 00000000fedcba18
2 3 a0000010 0 5fffffef5edcba88
2 0 a0000013 0 000000000000005e
3 0 a0000013 0000000000000080 0
2 0 a0000013 0 ffffffffffffff80

/* testbench/lsu_tb.sv */
// LSU testbench with clock, reset, memory model, pattern reader, checks and watchdog
module lsu_tb;
    import lsu_pkg::*;

    logic    clk, rst;
    funct3_t funct3;
    addr_t   lsu_addr, mem_r_addr, mem_w_addr;
    logic    lsu_r_ready, lsu_r_valid, lsu_w_valid, lsu_w_ready, lsu_busy;
    dword_t  lsu_r_data, lsu_w_data, mem_r_data, mem_w_data;
    logic    mem_r_req, mem_r_valid, mem_w_req, mem_w_done;
    beat_t   mem_r_len;
    strb_t   mem_w_strb;

    dword_t      model_mem [addr_t];   // Memory as written by the DUT
    dword_t      ref_mem [addr_t];     // Expected memory
    logic [31:0] lcg_state = 32'hd18cb56c;
    int          n_pat = 0;
    int          rd_reqs, rd_beats, wr_reqs;
    beat_t       last_len;
    addr_t       last_raddr, exp_waddr;
    strb_t       exp_strb;
    dword_t      exp_wdata;
    logic [3:0]  q_op [$];
    funct3_t     q_f3 [$];
    addr_t       q_addr [$];
    dword_t      q_wdata [$], q_exp [$];

    lsu dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int next_delay();  // 1 to 4 cycles
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return 1 + int'(lcg_state[17:16]);
    endfunction

    function automatic dword_t init_word(addr_t a);
        return {~a, a ^ 32'hfedcba98};
    endfunction

    function automatic dword_t merge_bytes(dword_t old, dword_t nw, strb_t s);
        dword_t r;
        r = old;
        for (int b = 0; b < 8; b++) begin
            if (s[b]) r[b*8 +: 8] = nw[b*8 +: 8];
        end
        return r;
    endfunction

    // Bytes covered by an access of 2**size bytes at byte offset off
    function automatic strb_t size_strb(funct3_t f, logic [2:0] off);
        strb_t s;
        int    n;
        n = 1 << f[1:0];
        for (int b = 0; b < 8; b++) s[b] = (b >= off) && (b < off + n);
        return s;
    endfunction

    task automatic fail_now(string msg);
        $display("[FAIL] %0t %s", $time, msg);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_dword(dword_t got, dword_t exp, string what);
        if (got !== exp) fail_now($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_strb(strb_t got, strb_t exp, string what);
        if (got !== exp) fail_now($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_addr(addr_t got, addr_t exp, string what);
        if (got !== exp) fail_now($sformatf("%s: got %h, expected %h", what, got, exp));
    endtask

    task automatic check_count(int got, int exp, string what);
        if (got != exp) fail_now($sformatf("%s: got %0d, expected %0d", what, got, exp));
    endtask

    // Memory read side answering one request at a time with random beat gaps
    initial begin : mem_read_model
        addr_t ra;
        forever begin
            @(posedge clk);
            #1;
            if (mem_r_req && !rst) begin
                ra         = mem_r_addr;
                last_raddr = ra;
                last_len   = mem_r_len;
                rd_reqs++;
                for (int b = 0; b <= int'(last_len); b++) begin
                    repeat (next_delay()) @(posedge clk);
                    #1;
                    mem_r_data  = model_mem.exists(ra) ? model_mem[ra] : init_word(ra);
                    mem_r_valid = 1'b1;
                    rd_beats++;
                    @(posedge clk);
                    #1;
                    mem_r_valid = 1'b0;
                    ra          = ra + 8;
                end
            end
        end
    end

    initial begin : mem_write_model
        dword_t mask;
        forever begin
            @(posedge clk);
            #1;
            if (mem_w_req && !rst) begin
                wr_reqs++;
                mask = merge_bytes('0, '1, exp_strb);
                check_addr(mem_w_addr, exp_waddr, "mem_w_addr");
                check_strb(mem_w_strb, exp_strb, "mem_w_strb");
                check_dword(mem_w_data & mask, exp_wdata & mask, "mem_w_data");
                repeat (next_delay()) @(posedge clk);
                #1;
                model_mem[exp_waddr] = merge_bytes(model_mem.exists(exp_waddr) ?
                    model_mem[exp_waddr] : init_word(exp_waddr), mem_w_data, mem_w_strb);
                mem_w_done = 1'b1;
                @(posedge clk);
                #1;
                mem_w_done = 1'b0;
            end
        end
    end

    task automatic run_access(int i);
        logic [3:0] op;
        int         cyc;
        addr_t      a;
        op          = q_op[i];
        a           = q_addr[i];
        funct3      = q_f3[i];
        lsu_addr    = a;
        lsu_w_data  = q_wdata[i];
        rd_reqs     = 0;
        rd_beats    = 0;
        wr_reqs     = 0;
        exp_waddr   = {a[31:3], 3'b000};
        exp_strb    = size_strb(q_f3[i], a[2:0]);
        exp_wdata   = q_wdata[i] << (8 * a[2:0]);
        lsu_w_valid = (op == 4'd3);
        lsu_r_ready = (op != 4'd3);
        cyc = 0;
        do begin
            @(posedge clk);
            #1;
            cyc++;
            check_count(lsu_busy, 1, $sformatf("pattern %0d lsu_busy during access", i));
        end while (!lsu_r_valid && !lsu_w_ready);
        if (op == 4'd3) begin
            check_count(lsu_w_ready, 1, $sformatf("pattern %0d completion", i));
            check_count(wr_reqs, 1, "memory writes");
            check_count(rd_reqs, 0, "memory reads on store");
            ref_mem[exp_waddr] = merge_bytes(ref_mem.exists(exp_waddr) ? ref_mem[exp_waddr] :
                init_word(exp_waddr), exp_wdata, exp_strb);
            check_dword(model_mem[exp_waddr], ref_mem[exp_waddr], "memory word after store");
        end else begin
            check_count(lsu_r_valid, 1, $sformatf("pattern %0d completion", i));
            check_dword(lsu_r_data, q_exp[i], $sformatf("pattern %0d load data", i));
            check_count(wr_reqs, 0, "memory writes on load");
            if (op == 4'd0) begin
                check_count(cyc, 2, "hit latency");
                check_count(rd_reqs, 0, "memory reads on hit");
            end else begin
                check_count(rd_reqs, 1, "memory reads on miss");
                check_count(rd_beats, (op == 4'd1) ? 8 : 1, "read beats");
                check_count(int'(last_len), (op == 4'd1) ? 7 : 0, "mem_r_len");
                check_addr(last_raddr, (op == 4'd1) ? {a[31:6], 6'b0} : exp_waddr, "mem_r_addr");
            end
        end
        @(posedge clk);
        #1;
        lsu_r_ready = 1'b0;
        lsu_w_valid = 1'b0;
        check_count(lsu_busy, 0, $sformatf("pattern %0d lsu_busy after completion", i));
    endtask

    initial begin : watchdog
        wait (n_pat > 0);
        repeat (n_pat * 200) @(posedge clk);
        $display("Timeout: the accesses did not complete in time");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : stimulus
        int          fd;
        int          code;
        string       line;
        logic [63:0] f_op, f_f3, f_a, f_wd, f_ex;
        rst = 1'b1;
        funct3 = '0;
        lsu_addr = '0;
        lsu_r_ready = 1'b0;
        lsu_w_valid = 1'b0;
        lsu_w_data = '0;
        mem_r_valid = 1'b0;
        mem_r_data = '0;
        mem_w_done = 1'b0;
        fd = $fopen("testbench/lsu_patterns.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open the pattern file");
            $display("Test failed");
            $fatal(1, "no patterns");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
                code = $sscanf(line, "%h %h %h %h %h", f_op, f_f3, f_a, f_wd, f_ex);
                if (code == 5) begin
                    q_op.push_back(f_op[3:0]);
                    q_f3.push_back(f_f3[2:0]);
                    q_addr.push_back(f_a[31:0]);
                    q_wdata.push_back(f_wd);
                    q_exp.push_back(f_ex);
                end
            end
        end
        $fclose(fd);
        n_pat = q_op.size();
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        check_count(lsu_busy, 0, "lsu_busy after reset");
        check_count(lsu_r_valid, 0, "lsu_r_valid after reset");
        check_count(lsu_w_ready, 0, "lsu_w_ready after reset");
        check_count(mem_r_req, 0, "mem_r_req after reset");
        check_count(mem_w_req, 0, "mem_w_req after reset");
        for (int i = 0; i < n_pat; i++) begin
            run_access(i);
        end
        $display("Test passed");
        $finish;
    end

endmodule

/* testbench/lsu_sva.sv */
// Bound assertions on completion pulses, busy, the memory port and the hit vector
module lsu_sva
    import lsu_pkg::*;
#(
    parameter int NUM_WAYS = lsu_pkg::NUM_WAYS
) (
    input logic                clk,
    input logic                rst,
    input logic                lsu_r_valid,
    input logic                lsu_w_ready,
    input logic                lsu_busy,
    input logic                mem_r_req,
    input logic                mem_w_req,
    input logic [NUM_WAYS-1:0] hit_vec
);
    a_r_pulse: assert property (@(posedge clk) disable iff (rst) lsu_r_valid |=> !lsu_r_valid)
        else $error("lsu_r_valid held for more than one cycle");
    a_w_pulse: assert property (@(posedge clk) disable iff (rst) lsu_w_ready |=> !lsu_w_ready)
        else $error("lsu_w_ready held for more than one cycle");
    // Back in idle right after a completion
    a_idle_busy: assert property (@(posedge clk) disable iff (rst)
        (lsu_r_valid || lsu_w_ready) |=> !lsu_busy)
        else $error("lsu_busy still high in the cycle after a completion pulse");
    a_mem_excl: assert property (@(posedge clk) disable iff (rst) !(mem_r_req && mem_w_req))
        else $error("memory read and write requested together");
    a_hit_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(hit_vec))
        else $error("more than one way hits");
endmodule

bind lsu lsu_sva #(.NUM_WAYS(NUM_WAYS)) sva0 (
    .clk         (clk),
    .rst         (rst),
    .lsu_r_valid (lsu_r_valid),
    .lsu_w_ready (lsu_w_ready),
    .lsu_busy    (lsu_busy),
    .mem_r_req   (mem_r_req),
    .mem_w_req   (mem_w_req),
    .hit_vec     (hit_way)
);

/* verilog/lsu.sv */
// Load and store unit top: aligner, cache controller, way array and hit selector
module lsu
    import lsu_pkg::*;
#(
    parameter int NUM_WAYS   = lsu_pkg::NUM_WAYS,
    parameter int NUM_SETS   = lsu_pkg::NUM_SETS,
    parameter int LINE_BEATS = lsu_pkg::LINE_BEATS
) (
    input  logic    clk,
    input  logic    rst,
    input  funct3_t funct3,
    input  addr_t   lsu_addr,
    input  logic    lsu_r_ready,
    output dword_t  lsu_r_data,
    output logic    lsu_r_valid,
    input  logic    lsu_w_valid,
    input  dword_t  lsu_w_data,
    output logic    lsu_w_ready,
    output logic    lsu_busy,

    output logic    mem_r_req,
    output addr_t   mem_r_addr,
    output beat_t   mem_r_len,
    input  logic    mem_r_valid,
    input  dword_t  mem_r_data,
    output logic    mem_w_req,
    output addr_t   mem_w_addr,
    output dword_t  mem_w_data,
    output strb_t   mem_w_strb,
    input  logic    mem_w_done
);
    dword_t              w_data_a;     // Store data shifted to its byte lanes
    strb_t               w_strb;
    dword_t              raw_r_data;   // 8-byte aligned read word
    logic                hit;
    logic [NUM_WAYS-1:0] hit_way;
    dword_t              hit_data;

    dcache_way_if #(
        .NUM_WAYS   (NUM_WAYS),
        .NUM_SETS   (NUM_SETS),
        .LINE_BEATS (LINE_BEATS)
    ) way_if ();

    lsu_align u_align (
        .funct3     (funct3),
        .lsu_addr   (lsu_addr),
        .lsu_w_data (lsu_w_data),
        .raw_r_data (raw_r_data),
        .w_data_a   (w_data_a),
        .w_strb     (w_strb),
        .lsu_r_data (lsu_r_data)
    );

    dcache_ctrl #(
        .NUM_WAYS   (NUM_WAYS),
        .NUM_SETS   (NUM_SETS),
        .LINE_BEATS (LINE_BEATS)
    ) u_ctrl (
        .clk         (clk),
        .rst         (rst),
        .lsu_addr    (lsu_addr),
        .lsu_r_ready (lsu_r_ready),
        .lsu_w_valid (lsu_w_valid),
        .w_data_a    (w_data_a),
        .w_strb      (w_strb),
        .hit         (hit),
        .hit_way     (hit_way),
        .hit_data    (hit_data),
        .raw_r_data  (raw_r_data),
        .lsu_r_valid (lsu_r_valid),
        .lsu_w_ready (lsu_w_ready),
        .lsu_busy    (lsu_busy),
        .mem_r_req   (mem_r_req),
        .mem_r_addr  (mem_r_addr),
        .mem_r_len   (mem_r_len),
        .mem_r_valid (mem_r_valid),
        .mem_r_data  (mem_r_data),
        .mem_w_req   (mem_w_req),
        .mem_w_addr  (mem_w_addr),
        .mem_w_data  (mem_w_data),
        .mem_w_strb  (mem_w_strb),
        .mem_w_done  (mem_w_done),
        .wif         (way_if.ctrl)
    );

    for (genvar g = 0; g < NUM_WAYS; g++) begin : g_way
        dcache_way #(
            .WAY_ID     (g),
            .NUM_SETS   (NUM_SETS),
            .LINE_BEATS (LINE_BEATS)
        ) u_way (
            .clk (clk),
            .rst (rst),
            .wif (way_if.way)
        );
    end

    dcache_hit_sel #(
        .NUM_WAYS (NUM_WAYS)
    ) u_hit_sel (
        .wif      (way_if.sel),
        .hit      (hit),
        .hit_way  (hit_way),
        .hit_data (hit_data)
    );

endmodule

/* verilog/dcache_hit_sel.sv */
// Hit reduction over all ways and read-word mux of the hitting way
module dcache_hit_sel
    import lsu_pkg::*;
#(
    parameter int NUM_WAYS = lsu_pkg::NUM_WAYS
) (
    dcache_way_if.sel           wif,
    output logic                hit,
    output logic [NUM_WAYS-1:0] hit_way,
    output dword_t              hit_data
);
    assign hit     = |wif.hit;
    assign hit_way = wif.hit;

    // AND-OR mux, at most one way hits
    always_comb begin
        hit_data = '0;
        for (int i = 0; i < NUM_WAYS; i++) begin
            hit_data = hit_data | (wif.rdata[i] & {64{wif.hit[i]}});
        end
    end

endmodule

/* verilog/dcache_way.sv */
// One cache way: tag, valid and data arrays with registered read and hit compare
module dcache_way
    import lsu_pkg::*;
#(
    parameter int WAY_ID     = 0,
    parameter int NUM_SETS   = lsu_pkg::NUM_SETS,
    parameter int LINE_BEATS = lsu_pkg::LINE_BEATS
) (
    input  logic       clk,
    input  logic       rst,
    dcache_way_if.way  wif
);
    localparam int IDX_W  = $clog2(NUM_SETS);
    localparam int BEAT_W = $clog2(LINE_BEATS);
    localparam int TAG_W  = 32 - IDX_W - BEAT_W - 3;

    logic [TAG_W-1:0]        tag_mem [NUM_SETS];
    logic [NUM_SETS-1:0]     valid;
    dword_t                  data_mem [NUM_SETS*LINE_BEATS];

    logic [TAG_W-1:0]        tag_q;
    logic                    valid_q;
    dword_t                  rdata_q;
    logic                    sel;
    logic [IDX_W+BEAT_W-1:0] word_addr;

    assign sel       = wif.fill_way[WAY_ID];
    assign word_addr = {wif.index, wif.beat[BEAT_W-1:0]};

    always_ff @(posedge clk) begin
        if (rst) begin
            valid   <= '0;
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid[wif.index];
            if (wif.tag_we && sel) begin
                valid[wif.index] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wif.tag_we && sel) begin
            tag_mem[wif.index] <= wif.tag;
        end
        if (wif.data_we && sel) begin
            for (int b = 0; b < 8; b++) begin
                if (wif.w_strb[b]) begin
                    data_mem[word_addr][b*8 +: 8] <= wif.w_data[b*8 +: 8];
                end
            end
        end
        tag_q   <= tag_mem[wif.index];  // Old contents on a same-cycle write
        rdata_q <= data_mem[word_addr];
    end

    assign wif.hit[WAY_ID]   = valid_q && (tag_q == wif.tag);
    assign wif.rdata[WAY_ID] = rdata_q;

endmodule

/* verilog/dcache_ctrl.sv */
// Data cache controller: lookup, line refill, write-through and uncached access,
// round-robin victim pointer
module dcache_ctrl
    import lsu_pkg::*;
#(
    parameter int NUM_WAYS   = lsu_pkg::NUM_WAYS,
    parameter int NUM_SETS   = lsu_pkg::NUM_SETS,
    parameter int LINE_BEATS = lsu_pkg::LINE_BEATS
) (
    input  logic                clk,
    input  logic                rst,
    input  addr_t               lsu_addr,
    input  logic                lsu_r_ready,
    input  logic                lsu_w_valid,
    input  dword_t              w_data_a,
    input  strb_t               w_strb,
    input  logic                hit,
    input  logic [NUM_WAYS-1:0] hit_way,
    input  dword_t              hit_data,
    output dword_t              raw_r_data,
    output logic                lsu_r_valid,
    output logic                lsu_w_ready,
    output logic                lsu_busy,
    output logic                mem_r_req,
    output addr_t               mem_r_addr,
    output beat_t               mem_r_len,
    input  logic                mem_r_valid,
    input  dword_t              mem_r_data,
    output logic                mem_w_req,
    output addr_t               mem_w_addr,
    output dword_t              mem_w_data,
    output strb_t               mem_w_strb,
    input  logic                mem_w_done,
    dcache_way_if.ctrl          wif
);
    localparam int    IDX_W     = $clog2(NUM_SETS);
    localparam int    OFF_W     = $clog2(LINE_BEATS) + 3;   // Byte offset in a line
    localparam int    TAG_W     = 32 - IDX_W - OFF_W;
    localparam beat_t LAST_BEAT = beat_t'(LINE_BEATS - 1);

    ctrl_state_t         state;
    logic                is_store;   // Access kind latched at accept
    beat_t               beat_cnt;   // Refill beat
    logic [NUM_WAYS-1:0] rr_way;     // One-hot victim
    dword_t              rdata_q;

    logic   device;
    logic   req;
    addr_t  addr_a;
    beat_t  addr_beat;
    logic   refill_beat;

    assign device      = lsu_addr[31:28] == DEVICE_NIBBLE;
    assign req         = lsu_r_ready || lsu_w_valid;
    assign addr_a      = {lsu_addr[31:3], 3'b000};
    assign addr_beat   = beat_t'(lsu_addr[OFF_W-1:3]);
    assign refill_beat = (state == REFILL) && mem_r_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            is_store <= 1'b0;
            beat_cnt <= '0;
            rr_way   <= NUM_WAYS'(1);
        end else begin
            case (state)
                IDLE: begin
                    if (req) begin
                        is_store <= lsu_w_valid;
                        beat_cnt <= '0;
                        if (!device) begin
                            state <= LOOKUP;
                        end else if (lsu_w_valid) begin
                            state <= MEM_WRITE;
                        end else begin
                            state <= UNC_READ;
                        end
                    end
                end
                LOOKUP: begin
                    if (is_store) begin
                        state <= MEM_WRITE;  // Hit word already updated here
                    end else if (hit) begin
                        state <= DONE;
                    end else begin
                        state <= REFILL;
                    end
                end
                REFILL: begin
                    if (mem_r_valid) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (beat_cnt == LAST_BEAT) begin
                            state <= REFILL_DONE;
                        end
                    end
                end
                REFILL_DONE: begin
                    rr_way <= {rr_way[NUM_WAYS-2:0], rr_way[NUM_WAYS-1]};
                    state  <= IDLE;  // Load request still high this cycle
                end
                MEM_WRITE: begin
                    if (mem_w_done) begin
                        state <= DONE;
                    end
                end
                UNC_READ: begin
                    if (mem_r_valid) begin
                        state <= DONE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Word returned to the core
    always_ff @(posedge clk) begin
        if (state == LOOKUP && hit) begin
            rdata_q <= hit_data;
        end else if ((refill_beat && beat_cnt == addr_beat) ||
                     (state == UNC_READ && mem_r_valid)) begin
            rdata_q <= mem_r_data;
        end
    end

    assign raw_r_data  = rdata_q;
    assign lsu_r_valid = (state == REFILL_DONE) || (state == DONE && !is_store);
    assign lsu_w_ready = (state == DONE) && is_store;
    assign lsu_busy    = state != IDLE;

    assign wif.index    = lsu_addr[OFF_W +: IDX_W];
    assign wif.tag      = lsu_addr[31 -: TAG_W];
    assign wif.beat     = (state == REFILL) ? beat_cnt : addr_beat;
    assign wif.w_data   = (state == REFILL) ? mem_r_data : w_data_a;
    assign wif.w_strb   = (state == REFILL) ? 8'hFF : w_strb;
    assign wif.fill_way = (state == REFILL) ? rr_way : hit_way;
    assign wif.tag_we   = refill_beat && (beat_cnt == LAST_BEAT);
    assign wif.data_we  = refill_beat || (state == LOOKUP && is_store && hit);

    assign mem_r_req  = (state == REFILL) || (state == UNC_READ);
    assign mem_r_addr = (state == REFILL) ? {lsu_addr[31:OFF_W], {OFF_W{1'b0}}} : addr_a;
    assign mem_r_len  = (state == REFILL) ? LAST_BEAT : beat_t'(0);
    assign mem_w_req  = state == MEM_WRITE;
    assign mem_w_addr = addr_a;
    assign mem_w_data = w_data_a;
    assign mem_w_strb = w_strb;

endmodule

/* verilog/lsu_align.sv */
// Store strobe and lane shift, load shift with sign or zero extension
module lsu_align
    import lsu_pkg::*;
(
    input  funct3_t funct3,
    input  addr_t   lsu_addr,
    input  dword_t  lsu_w_data,
    input  dword_t  raw_r_data,
    output dword_t  w_data_a,
    output strb_t   w_strb,
    output dword_t  lsu_r_data
);
    logic [2:0] byte_off;
    logic [5:0] bit_off;
    dword_t     r_shift;

    assign byte_off = lsu_addr[2:0];
    assign bit_off  = {byte_off, 3'b000};
    assign r_shift  = raw_r_data >> bit_off;  // Addressed byte down to lane 0

    always_comb begin
        w_data_a = lsu_w_data << bit_off;
        case (funct3)
            SB: begin
                w_strb = 8'b0000_0001 << byte_off;
            end
            SH: begin
                w_strb = 8'b0000_0011 << byte_off;
            end
            SW: begin
                w_strb = 8'b0000_1111 << byte_off;
            end
            SD: begin
                w_strb = 8'b1111_1111;
            end
            default: begin
                w_strb   = '0;
                w_data_a = '0;
            end
        endcase
    end

    always_comb begin
        case (funct3)
            LB: begin
                lsu_r_data = {{56{r_shift[7]}}, r_shift[7:0]};
            end
            LH: begin
                lsu_r_data = {{48{r_shift[15]}}, r_shift[15:0]};
            end
            LW: begin
                lsu_r_data = {{32{r_shift[31]}}, r_shift[31:0]};
            end
            LD: begin
                lsu_r_data = r_shift;
            end
            LBU: begin
                lsu_r_data = {56'b0, r_shift[7:0]};
            end
            LHU: begin
                lsu_r_data = {48'b0, r_shift[15:0]};
            end
            LWU: begin
                lsu_r_data = {32'b0, r_shift[31:0]};
            end
            default: begin
                lsu_r_data = '0;
            end
        endcase
    end

endmodule

/* verilog/dcache_way_if.sv */
// Cache controller to way array bus, plus the per-way hit and read returns
interface dcache_way_if
    import lsu_pkg::*;
#(
    parameter int NUM_WAYS   = lsu_pkg::NUM_WAYS,
    parameter int NUM_SETS   = lsu_pkg::NUM_SETS,
    parameter int LINE_BEATS = lsu_pkg::LINE_BEATS
) ();
    localparam int IDX_W = $clog2(NUM_SETS);
    localparam int TAG_W = 32 - IDX_W - $clog2(LINE_BEATS) - 3;

    logic [IDX_W-1:0]    index;
    logic [TAG_W-1:0]    tag;        // Lookup tag, also the tag written on refill
    beat_t               beat;
    dword_t              w_data;
    strb_t               w_strb;
    logic [NUM_WAYS-1:0] fill_way;   // Way written by tag_we or data_we
    logic                tag_we;
    logic                data_we;
    logic [NUM_WAYS-1:0] hit;
    dword_t              rdata [NUM_WAYS];

    modport ctrl (output index, tag, beat, w_data, w_strb, fill_way, tag_we, data_we);
    modport way  (input index, tag, beat, w_data, w_strb, fill_way, tag_we, data_we,
                  output hit, rdata);
    modport sel  (input hit, rdata);

endinterface

/* verilog/lsu_pkg.sv */
// LSU shared definitions: cache geometry, width types, funct3 codes,
// controller states
package lsu_pkg;

    parameter int NUM_WAYS   = 4;
    parameter int NUM_SETS   = 16;
    parameter int LINE_BEATS = 8;                 // 64-bit beats per line

    typedef logic [31:0]         addr_t;
    typedef logic [63:0]         dword_t;
    typedef logic [7:0]          strb_t;
    typedef logic [21:0]         tag_t;           // Address bits above the index
    typedef logic [3:0]          index_t;
    typedef logic [2:0]          beat_t;
    typedef logic [NUM_WAYS-1:0] way_sel_t;       // One-hot
    typedef logic [2:0]          funct3_t;

    // Load sizes
    localparam funct3_t LB  = 3'b000;
    localparam funct3_t LH  = 3'b001;
    localparam funct3_t LW  = 3'b010;
    localparam funct3_t LD  = 3'b011;
    localparam funct3_t LBU = 3'b100;
    localparam funct3_t LHU = 3'b101;
    localparam funct3_t LWU = 3'b110;

    // Store sizes
    localparam funct3_t SB  = 3'b000;
    localparam funct3_t SH  = 3'b001;
    localparam funct3_t SW  = 3'b010;
    localparam funct3_t SD  = 3'b011;

    localparam logic [3:0] DEVICE_NIBBLE = 4'hA;  // Uncached space

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        REFILL,
        REFILL_DONE,
        MEM_WRITE,
        UNC_READ,
        DONE
    } ctrl_state_t;

endpackage
